//--- bench/blit_data_checks.svh
// Blitter data path reference model and typed result compares used by the testbench
`ifndef BLIT_DATA_CHECKS_SVH
`define BLIT_DATA_CHECKS_SVH

// Load bus carries memory data or the GPU word doubled
function automatic phrase_t load_bus_value(input logic use_mem, input phrase_t mem,
		input half_t gpu);
	if (use_mem) begin
		return mem;
	end
	return {gpu, gpu};
endfunction

// Bytes 0 to 3 follow enable bit 0 and bytes 4 to 7 follow bit 1
function automatic phrase_t apply_half_load(input phrase_t old_val, input phrase_t new_val,
		input half_en_t en);
	phrase_t result;
	result = old_val;
	for (int b = 0; b < PHRASE_BYTES; b++) begin
		if (en[b / 4]) begin
			result[b*8 +: 8] = new_val[b*8 +: 8];
		end
	end
	return result;
endfunction

// Output byte b comes from byte b+shift of the pair with the previous fetch in the low bytes
function automatic phrase_t align_source(input phrase_t cur, input phrase_t prev,
		input byte_shift_t shift);
	phrase_t result;
	int src_byte;
	for (int b = 0; b < PHRASE_BYTES; b++) begin
		src_byte = b + int'(shift);
		if (src_byte < PHRASE_BYTES) begin
			result[b*8 +: 8] = prev[src_byte*8 +: 8];
		end else begin
			result[b*8 +: 8] = cur[(src_byte - PHRASE_BYTES)*8 +: 8];
		end
	end
	return result;
endfunction

// Truth table lookup with the source bit as the high index bit
function automatic phrase_t lfu_lookup(input lfu_func_t func, input phrase_t s,
		input phrase_t d);
	phrase_t result;
	for (int i = 0; i < PHRASE_BYTES*8; i++) begin
		result[i] = func[{s[i], d[i]}];
	end
	return result;
endfunction

function automatic byte_mask_t compare_bytes(input phrase_t pat, input phrase_t other);
	byte_mask_t result;
	for (int b = 0; b < PHRASE_BYTES; b++) begin
		result[b] = (pat[b*8 +: 8] == other[b*8 +: 8]);
	end
	return result;
endfunction

// Selected phrase with inhibited bytes taken from dest
function automatic phrase_t masked_write(input wr_sel_e sel, input phrase_t lfu,
		input phrase_t pat, input phrase_t dst, input phrase_t src, input byte_mask_t inh_n);
	phrase_t chosen;
	phrase_t result;
	case (sel)
		WR_LFU:     chosen = lfu;
		WR_PATTERN: chosen = pat;
		WR_DEST:    chosen = dst;
		default:    chosen = src;
	endcase
	for (int b = 0; b < PHRASE_BYTES; b++) begin
		result[b*8 +: 8] = inh_n[b] ? chosen[b*8 +: 8] : dst[b*8 +: 8];
	end
	return result;
endfunction

task automatic check_phrase(input string name, input phrase_t exp_val, input phrase_t act_val);
	if (act_val !== exp_val) begin
		phrase_errs++;
		$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp_val, act_val);
	end
endtask

task automatic check_mask(input string name, input byte_mask_t exp_val,
		input byte_mask_t act_val);
	if (act_val !== exp_val) begin
		mask_errs++;
		$display("FAIL t=%0t %s expected %b actual %b", $time, name, exp_val, act_val);
	end
endtask

task automatic check_bit(input string name, input logic exp_val, input logic act_val);
	if (act_val !== exp_val) begin
		bit_errs++;
		$display("FAIL t=%0t %s expected %b actual %b", $time, name, exp_val, act_val);
	end
endtask

`endif

//--- bench/blit_data_tb.sv
// Testbench for the blitter phrase data path with random stimulus and a reference model
module blit_data_tb
	import blit_data_pkg::*;
();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 2;
	localparam int LOAD_ROUNDS  = 24;
	localparam int CMP_ROUNDS   = 16;
	localparam int INH_ROUNDS   = 40;
	localparam int TEST_CYCLES  = RESET_CYCLES + 2 + LOAD_ROUNDS*4 + 16 + 48
	                            + CMP_ROUNDS*2 + INH_ROUNDS + 4;

	logic        sys_clk;
	logic        rst_n;
	half_t       gpu_din;
	phrase_t     mem_data;
	logic        mem_sel;
	logic        load_strobe;
	half_en_t    srcd_ld;
	half_en_t    dstd_ld;
	half_en_t    patd_ld;
	logic        srcd_read;
	byte_shift_t src_shift;
	lfu_func_t   lfu_func;
	logic        cmp_dst;
	wr_sel_e     data_sel;
	logic        data_ena;
	byte_mask_t  dbinh_n;
	phrase_t     wdata_out;
	logic        wdata_oe;
	byte_mask_t  dcomp;

	// Shadow registers and expected outputs
	phrase_t sh_cur;
	phrase_t sh_prev;
	phrase_t sh_dest;
	phrase_t sh_pat;
	phrase_t sh_src;
	phrase_t ld_val;
	phrase_t exp_wdata;
	logic    exp_oe;

	int phrase_errs = 0;
	int mask_errs = 0;
	int bit_errs = 0;
	logic [31:0] rng_state = 32'd15;

	`include "blit_data_checks.svh"

	blit_data_top i_blit_data_top (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.gpu_din     (gpu_din),
		.mem_data    (mem_data),
		.mem_sel     (mem_sel),
		.load_strobe (load_strobe),
		.srcd_ld     (srcd_ld),
		.dstd_ld     (dstd_ld),
		.patd_ld     (patd_ld),
		.srcd_read   (srcd_read),
		.src_shift   (src_shift),
		.lfu_func    (lfu_func),
		.cmp_dst     (cmp_dst),
		.data_sel    (data_sel),
		.data_ena    (data_ena),
		.dbinh_n     (dbinh_n),
		.wdata_out   (wdata_out),
		.wdata_oe    (wdata_oe),
		.dcomp       (dcomp)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic idle_inputs();
		load_strobe = 1'b0;
		srcd_ld = 2'b00;
		dstd_ld = 2'b00;
		patd_ld = 2'b00;
		srcd_read = 1'b0;
		data_ena = 1'b0;
		dbinh_n = 8'hff;
	endtask

	task automatic load_cycle(input logic use_mem, input half_en_t s_en, input half_en_t d_en,
			input half_en_t p_en, input logic rd, input phrase_t data);
		@(negedge sys_clk);
		idle_inputs();
		mem_sel = use_mem;
		mem_data = data;
		gpu_din = next_rand();
		load_strobe = 1'b1;
		srcd_ld = s_en;
		dstd_ld = d_en;
		patd_ld = p_en;
		srcd_read = rd;
	endtask

	task automatic write_cycle(input wr_sel_e sel, input byte_mask_t inh_n);
		@(negedge sys_clk);
		idle_inputs();
		data_sel = sel;
		dbinh_n = inh_n;
		data_ena = 1'b1;
	endtask

	initial begin
		sys_clk = 1'b0;
		forever begin
			#(CLK_PERIOD/2) sys_clk = ~sys_clk;
		end
	end

	// Reference model steps at each rising edge and checks the outputs 1 unit later
	always begin
		@(posedge sys_clk);
		if (!rst_n) begin
			sh_cur = '0;
			sh_prev = '0;
			sh_dest = '0;
			sh_pat = '0;
			exp_wdata = '0;
			exp_oe = 1'b0;
		end else begin
			exp_oe = data_ena;
			sh_src = align_source(sh_cur, sh_prev, src_shift);
			if (data_ena) begin
				exp_wdata = masked_write(data_sel, lfu_lookup(lfu_func, sh_src, sh_dest),
					sh_pat, sh_dest, sh_src, dbinh_n);
			end
			if (load_strobe) begin
				ld_val = load_bus_value(mem_sel, mem_data, gpu_din);
				if (srcd_read) begin
					sh_prev = sh_cur;
				end
				sh_cur = apply_half_load(sh_cur, ld_val, srcd_ld);
				sh_dest = apply_half_load(sh_dest, ld_val, dstd_ld);
				sh_pat = apply_half_load(sh_pat, ld_val, patd_ld);
			end
		end
		#1;
		sh_src = align_source(sh_cur, sh_prev, src_shift);
		check_mask("dcomp", compare_bytes(sh_pat, cmp_dst ? sh_dest : sh_src), dcomp);
		check_bit("wdata_oe", exp_oe, wdata_oe);
		check_phrase("wdata_out", exp_wdata, wdata_out);
	end

	initial begin
		#((TEST_CYCLES + 20) * CLK_PERIOD);
		$display("Timeout: test sequence did not finish within %0d cycles", TEST_CYCLES + 20);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [31:0] r;
		phrase_t cmp_val;
		phrase_t pat_val;
		int total_errs;
		rst_n = 1'b0;
		gpu_din = '0;
		mem_data = '0;
		mem_sel = 1'b0;
		src_shift = '0;
		lfu_func = '0;
		cmp_dst = 1'b0;
		data_sel = WR_LFU;
		idle_inputs();
		repeat (RESET_CYCLES) @(negedge sys_clk);
		rst_n = 1'b1;

		// Dest reads back as zero straight after reset
		write_cycle(WR_DEST, 8'hff);
		@(negedge sys_clk);
		idle_inputs();

		// Mixed half loads from memory and GPU with the strobe sometimes dropped
		for (int i = 0; i < LOAD_ROUNDS; i++) begin
			r = next_rand();
			load_cycle(r[0], r[2:1], r[4:3], r[6:5], r[7], {next_rand(), next_rand()});
			load_strobe = r[8] | r[9];
			src_shift = r[12:10];
			write_cycle(WR_DEST, 8'hff);
			write_cycle(WR_PATTERN, 8'hff);
			write_cycle(WR_SOURCE, 8'hff);
		end

		for (int sh = 0; sh < PHRASE_BYTES; sh++) begin
			load_cycle(1'b1, 2'b11, 2'b00, 2'b00, 1'b1, {next_rand(), next_rand()});
			write_cycle(WR_SOURCE, 8'hff);
			src_shift = sh[2:0];
		end

		for (int f = 0; f < 16; f++) begin
			load_cycle(1'b1, 2'b11, 2'b00, 2'b00, 1'b1, {next_rand(), next_rand()});
			load_cycle(1'b1, 2'b00, 2'b11, 2'b00, 1'b0, {next_rand(), next_rand()});
			r = next_rand();
			src_shift = r[2:0];
			write_cycle(WR_LFU, 8'hff);
			lfu_func = f[3:0];
		end

		// Pattern loads with some bytes copied from the comparand
		for (int i = 0; i < CMP_ROUNDS; i++) begin
			r = next_rand();
			pat_val = {next_rand(), next_rand()};
			@(negedge sys_clk);
			idle_inputs();
			cmp_dst = i[0];
			src_shift = r[10:8];
			cmp_val = cmp_dst ? sh_dest : align_source(sh_cur, sh_prev, src_shift);
			for (int b = 0; b < PHRASE_BYTES; b++) begin
				if (r[b]) begin
					pat_val[b*8 +: 8] = cmp_val[b*8 +: 8];
				end
			end
			mem_sel = 1'b1;
			mem_data = pat_val;
			load_strobe = 1'b1;
			patd_ld = 2'b11;
			load_cycle(r[11], r[13:12], r[15:14], 2'b00, r[16], {next_rand(), next_rand()});
		end

		// Inhibit, hold and output enable with random loads alongside
		for (int i = 0; i < INH_ROUNDS; i++) begin
			r = next_rand();
			@(negedge sys_clk);
			idle_inputs();
			data_ena = r[0];
			data_sel = wr_sel_e'(r[3:2]);
			dbinh_n = r[11:4];
			lfu_func = r[15:12];
			src_shift = r[18:16];
			cmp_dst = r[19];
			if (r[20]) begin
				load_strobe = 1'b1;
				mem_sel = r[21];
				mem_data = {next_rand(), next_rand()};
				gpu_din = next_rand();
				srcd_ld = r[23:22];
				dstd_ld = r[25:24];
				patd_ld = r[27:26];
				srcd_read = r[28];
			end
		end

		@(negedge sys_clk);
		idle_inputs();
		repeat (3) @(negedge sys_clk);
		total_errs = phrase_errs + mask_errs + bit_errs;
		$display("Errors: phrase %0d, mask %0d, bit %0d, total %0d",
			phrase_errs, mask_errs, bit_errs, total_errs);
		if (total_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- logic/blit_data_pkg.sv
// Blitter phrase data path types shared by the loader, aligner, ALU and write mux
package blit_data_pkg;

	// Bytes per 64-bit memory phrase
	localparam int PHRASE_BYTES = 8;

	// One memory phrase, byte 0 in bits 7:0
	typedef logic [PHRASE_BYTES*8-1:0] phrase_t;

	// Half phrase, the width of the GPU data bus
	typedef logic [31:0] half_t;

	// One bit per phrase byte, for compare results and write inhibit
	typedef logic [PHRASE_BYTES-1:0] byte_mask_t;

	// Per-half load enables, bit 0 is the low half
	typedef logic [1:0] half_en_t;

	// Source alignment in whole bytes
	typedef logic [2:0] byte_shift_t;

	// Logic function truth table, indexed by {source, dest}
	typedef logic [3:0] lfu_func_t;

	// Write phrase source
	typedef enum logic [1:0] {
		WR_LFU     = 2'd0,
		WR_PATTERN = 2'd1,
		WR_DEST    = 2'd2,
		WR_SOURCE  = 2'd3
	} wr_sel_e;

endpackage

//--- logic/blit_data_top.sv
// Blitter phrase data path top level joining the loader, source aligner, ALU and write mux
module blit_data_top
	import blit_data_pkg::*;
(
	input  logic        sys_clk,
	input  logic        rst_n,

	// Load side
	input  half_t       gpu_din,
	input  phrase_t     mem_data,
	input  logic        mem_sel,
	input  logic        load_strobe,
	input  half_en_t    srcd_ld,
	input  half_en_t    dstd_ld,
	input  half_en_t    patd_ld,
	input  logic        srcd_read,

	// Processing controls
	input  byte_shift_t src_shift,
	input  lfu_func_t   lfu_func,
	input  logic        cmp_dst,

	// Write side
	input  wr_sel_e     data_sel,
	input  logic        data_ena,
	input  byte_mask_t  dbinh_n,

	output phrase_t     wdata_out,
	output logic        wdata_oe,
	output byte_mask_t  dcomp
);

	phrase_t src_cur;
	phrase_t src_prev;
	phrase_t dest;
	phrase_t pattern;
	phrase_t src_aligned;
	phrase_t lfu_out;

	phrase_load i_phrase_load (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.gpu_din     (gpu_din),
		.mem_data    (mem_data),
		.mem_sel     (mem_sel),
		.load_strobe (load_strobe),
		.srcd_ld     (srcd_ld),
		.srcd_read   (srcd_read),
		.dstd_ld     (dstd_ld),
		.patd_ld     (patd_ld),
		.src_cur     (src_cur),
		.src_prev    (src_prev),
		.dest        (dest),
		.pattern     (pattern)
	);

	source_align i_source_align (
		.src_cur     (src_cur),
		.src_prev    (src_prev),
		.src_shift   (src_shift),
		.src_aligned (src_aligned)
	);

	pixel_alu i_pixel_alu (
		.src_aligned (src_aligned),
		.dest        (dest),
		.pattern     (pattern),
		.lfu_func    (lfu_func),
		.cmp_dst     (cmp_dst),
		.lfu_out     (lfu_out),
		.dcomp       (dcomp)
	);

	write_data_mux i_write_data_mux (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.lfu_out     (lfu_out),
		.pattern     (pattern),
		.dest        (dest),
		.src_aligned (src_aligned),
		.data_sel    (data_sel),
		.data_ena    (data_ena),
		.dbinh_n     (dbinh_n),
		.wdata_out   (wdata_out),
		.wdata_oe    (wdata_oe)
	);

endmodule

//--- logic/phrase_load.sv
// Phrase loader choosing memory or GPU data and holding the source, dest and pattern registers
module phrase_load
	import blit_data_pkg::*;
(
	input  logic     sys_clk,
	input  logic     rst_n,
	input  half_t    gpu_din,
	input  phrase_t  mem_data,
	input  logic     mem_sel,
	input  logic     load_strobe,
	input  half_en_t srcd_ld,
	input  logic     srcd_read,
	input  half_en_t dstd_ld,
	input  half_en_t patd_ld,
	output phrase_t  src_cur,
	output phrase_t  src_prev,
	output phrase_t  dest,
	output phrase_t  pattern
);

	phrase_t load_data;
	half_en_t src_en;
	half_en_t dst_en;
	half_en_t pat_en;
	logic src_shift_en;

	// Replace the enabled halves of a phrase with the load data
	function automatic phrase_t merge_halves(
		input phrase_t  old_val,
		input phrase_t  new_val,
		input half_en_t en
	);
		phrase_t result;
		result = old_val;
		if (en[0]) begin
			result[31:0] = new_val[31:0];
		end
		if (en[1]) begin
			result[63:32] = new_val[63:32];
		end
		return result;
	endfunction

	// GPU word goes to both halves when memory is not the source
	assign load_data = mem_sel ? mem_data : {gpu_din, gpu_din};

	// Strobe qualifies every load
	assign src_en       = load_strobe ? srcd_ld : 2'b00;
	assign dst_en       = load_strobe ? dstd_ld : 2'b00;
	assign pat_en       = load_strobe ? patd_ld : 2'b00;
	assign src_shift_en = load_strobe & srcd_read;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			src_cur  <= '0;
			src_prev <= '0;
			dest     <= '0;
			pattern  <= '0;
		end else begin
			src_cur <= merge_halves(src_cur, load_data, src_en);
			dest    <= merge_halves(dest, load_data, dst_en);
			pattern <= merge_halves(pattern, load_data, pat_en);
			// Old source moves down before the new fetch lands
			if (src_shift_en) begin
				src_prev <= src_cur;
			end
		end
	end

	// The strobe comes from the blitter sequencer and must be a clean level
	a_strobe_known: assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		!$isunknown(load_strobe)
	);

endmodule

//--- logic/pixel_alu.sv
// Pixel logic function unit with bytewise pattern compare
module pixel_alu
	import blit_data_pkg::*;
(
	input  phrase_t    src_aligned,
	input  phrase_t    dest,
	input  phrase_t    pattern,
	input  lfu_func_t  lfu_func,
	input  logic       cmp_dst,
	output phrase_t    lfu_out,
	output byte_mask_t dcomp
);

	phrase_t cmp_data;

	// Each term picks one truth-table entry, index is {s, d}
	assign lfu_out = ({64{lfu_func[3]}} &  src_aligned &  dest)
	               | ({64{lfu_func[2]}} &  src_aligned & ~dest)
	               | ({64{lfu_func[1]}} & ~src_aligned &  dest)
	               | ({64{lfu_func[0]}} & ~src_aligned & ~dest);

	// Pattern is compared against dest or the aligned source
	assign cmp_data = cmp_dst ? dest : src_aligned;

	always_comb begin
		for (int i = 0; i < PHRASE_BYTES; i++) begin
			dcomp[i] = (pattern[i*8 +: 8] == cmp_data[i*8 +: 8]);
		end
	end

endmodule

//--- logic/source_align.sv
// Source byte shifter building one aligned phrase from the current and previous fetches
module source_align
	import blit_data_pkg::*;
(
	input  phrase_t     src_cur,
	input  phrase_t     src_prev,
	input  byte_shift_t src_shift,
	output phrase_t     src_aligned
);

	localparam int PAIR_BITS = 2 * PHRASE_BYTES * 8;

	logic [PAIR_BITS-1:0] src_pair;
	logic [PAIR_BITS-1:0] src_shifted;
	logic [5:0] shift_bits;

	// Newer fetch sits above the older one
	assign src_pair = {src_cur, src_prev};

	// Whole-byte shift amount
	assign shift_bits = {src_shift, 3'b000};

	assign src_shifted = src_pair >> shift_bits;

	// Low phrase straddles the two fetches
	assign src_aligned = src_shifted[PHRASE_BYTES*8-1:0];

endmodule

//--- logic/write_data_mux.sv
// Write phrase mux with per-byte inhibit and output register
module write_data_mux
	import blit_data_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst_n,
	input  phrase_t    lfu_out,
	input  phrase_t    pattern,
	input  phrase_t    dest,
	input  phrase_t    src_aligned,
	input  wr_sel_e    data_sel,
	input  logic       data_ena,
	input  byte_mask_t dbinh_n,
	output phrase_t    wdata_out,
	output logic       wdata_oe
);

	phrase_t sel_data;
	phrase_t masked_data;

	always_comb begin
		case (data_sel)
			WR_PATTERN: sel_data = pattern;
			WR_DEST:    sel_data = dest;
			WR_SOURCE:  sel_data = src_aligned;
			default:    sel_data = lfu_out;
		endcase
	end

	// Inhibited bytes write back what is already in memory
	always_comb begin
		for (int i = 0; i < PHRASE_BYTES; i++) begin
			masked_data[i*8 +: 8] = dbinh_n[i] ? sel_data[i*8 +: 8] : dest[i*8 +: 8];
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			wdata_out <= '0;
			wdata_oe  <= 1'b0;
		end else begin
			wdata_oe <= data_ena;
			// Holds between writes
			if (data_ena) begin
				wdata_out <= masked_data;
			end
		end
	end

	// Bus must be released as soon as reset has been seen
	a_oe_reset: assert property (
		@(posedge sys_clk) !rst_n |=> !wdata_oe
	);

	// Output enable tracks the write request one cycle late
	a_oe_follow: assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		1'b1 |=> (wdata_oe == $past(data_ena))
	);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the blitter data path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module blit_data_tb -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/Vblit_data_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

//--- vlog.f
+incdir+bench
logic/blit_data_pkg.sv
logic/phrase_load.sv
logic/source_align.sv
logic/pixel_alu.sv
logic/write_data_mux.sv
logic/blit_data_top.sv
bench/blit_data_tb.sv
